//--- source/sdram_cmd_pkg.sv
`default_nettype none

// Pin-level view of the SDRAM command interface
package sdram_cmd_pkg;

    localparam int ADDR_WIDTH = 13;
    localparam int DATA_WIDTH = 16;
    // One mask bit per data byte
    localparam int DQM_WIDTH = DATA_WIDTH / 8;
    // Widest column the address word can carry below A10
    localparam int COL_FIELD_WIDTH = 10;

    // Everything sampled from the pins on one edge
    typedef struct packed {
        logic                  cs;
        logic                  ras;
        logic                  cas;
        logic                  we;
        logic [ADDR_WIDTH-1:0] a;
        logic [1:0]            ba;
        logic [DQM_WIDTH-1:0]  dqm;
    } pins_t;

    // Decoded command, cs/ras/cas/we all active low
    typedef enum logic [2:0] {
        cmd_inhibit,
        cmd_nop,
        cmd_active,
        cmd_read,
        cmd_write,
        cmd_precharge,
        cmd_refresh,
        cmd_load_mode
    } cmd_e;

    // Address word during LOAD MODE
    typedef struct packed {
        // Write burst mode and op mode, not modeled
        logic [5:0] reserved;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_code;
    } mode_fields_t;

    // Address word during READ, WRITE and PRECHARGE
    typedef struct packed {
        logic [1:0]                 reserved;
        // A10, auto precharge on access or all banks on PRECHARGE
        logic                       all_banks;
        logic [COL_FIELD_WIDTH-1:0] column;
    } col_fields_t;

    // Same 13 address pins, meaning depends on the command
    typedef union packed {
        mode_fields_t mode;
        col_fields_t  col;
    } addr_word_u;

    // Burst request toward the engine, only for an open bank
    typedef struct packed {
        logic                       start_read;
        logic                       start_write;
        logic [1:0]                 bank;
        logic [ADDR_WIDTH-1:0]      row;
        logic [COL_FIELD_WIDTH-1:0] column;
    } access_t;

endpackage

`default_nettype wire

//--- source/sdram_geom_pkg.sv
`default_nettype none

// Array geometry and burst engine encodings
package sdram_geom_pkg;

    localparam int BANK_COUNT = 4;

    // Kept small so the whole array fits in simulation
    localparam int DEF_ROW_WIDTH = 4;
    localparam int DEF_COL_WIDTH = 5;

    localparam int BANK_WIDTH = $clog2(BANK_COUNT);

    typedef logic [BANK_WIDTH-1:0] bank_t;

    // Burst engine states
    typedef enum logic [1:0] {
        // No burst in flight
        st_idle,
        // Waiting out the CAS latency
        st_read_wait,
        // One array read per cycle
        st_read_burst,
        // Words 1 and up of a write burst
        st_write_burst
    } burst_state_e;

endpackage

`default_nettype wire

//--- source/sdram_cmd_decode.sv
`default_nettype none

module sdram_cmd_decode #(
    parameter int ROW_WIDTH = sdram_geom_pkg::DEF_ROW_WIDTH,
    parameter int COL_WIDTH = sdram_geom_pkg::DEF_COL_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_cmd_pkg::pins_t    pins,
    output sdram_cmd_pkg::access_t  access,
    output logic [3:0]              burst_len,
    output logic [1:0]              cas_lat
);

    sdram_cmd_pkg::cmd_e       cmd;
    sdram_cmd_pkg::addr_word_u addr;

    // Open-row table, one entry per bank
    logic                 open_flag [sdram_geom_pkg::BANK_COUNT];
    logic [ROW_WIDTH-1:0] open_row  [sdram_geom_pkg::BANK_COUNT];

    assign addr = pins.a;

    // Command truth table
    always_comb begin
        if (pins.cs) begin
            cmd = sdram_cmd_pkg::cmd_inhibit;
        end else begin
            case ({pins.ras, pins.cas, pins.we})
                3'b011:  cmd = sdram_cmd_pkg::cmd_active;
                3'b101:  cmd = sdram_cmd_pkg::cmd_read;
                3'b100:  cmd = sdram_cmd_pkg::cmd_write;
                3'b010:  cmd = sdram_cmd_pkg::cmd_precharge;
                3'b001:  cmd = sdram_cmd_pkg::cmd_refresh;
                3'b000:  cmd = sdram_cmd_pkg::cmd_load_mode;
                // Burst terminate falls in here too
                default: cmd = sdram_cmd_pkg::cmd_nop;
            endcase
        end
    end

    // Access request, row taken from the open-row table
    always_comb begin
        access = '0;
        if (open_flag[pins.ba]) begin
            access.start_read  = (cmd == sdram_cmd_pkg::cmd_read);
            access.start_write = (cmd == sdram_cmd_pkg::cmd_write);
        end
        access.bank                   = pins.ba;
        access.row[ROW_WIDTH-1:0]     = open_row[pins.ba];
        access.column[COL_WIDTH-1:0]  = addr.col.column[COL_WIDTH-1:0];
    end

    // Mode register and bank open flags
    always_ff @(posedge clk) begin
        if (rst) begin
            burst_len <= 4'd1;
            cas_lat   <= 2'd2;
            for (int i = 0; i < sdram_geom_pkg::BANK_COUNT; i++) begin
                open_flag[i] <= 1'b0;
            end
        end else begin
            case (cmd)
                sdram_cmd_pkg::cmd_load_mode: begin
                    // Burst type ignored, always sequential
                    case (addr.mode.burst_code)
                        3'd1:    burst_len <= 4'd2;
                        3'd2:    burst_len <= 4'd4;
                        3'd3:    burst_len <= 4'd8;
                        default: burst_len <= 4'd1;
                    endcase
                    // Only CL 2 and 3 supported
                    cas_lat <= (addr.mode.cas_latency == 3'd3) ? 2'd3 : 2'd2;
                end
                sdram_cmd_pkg::cmd_active: begin
                    open_flag[pins.ba] <= 1'b1;
                end
                sdram_cmd_pkg::cmd_precharge: begin
                    if (addr.col.all_banks) begin
                        for (int i = 0; i < sdram_geom_pkg::BANK_COUNT; i++) begin
                            open_flag[i] <= 1'b0;
                        end
                    end else begin
                        open_flag[pins.ba] <= 1'b0;
                    end
                end
                // Refresh accepted, nothing to do
                sdram_cmd_pkg::cmd_refresh: ;
                default: ;
            endcase
        end
    end

    // Row latched on ACTIVE
    always_ff @(posedge clk) begin
        if (cmd == sdram_cmd_pkg::cmd_active) begin
            open_row[pins.ba] <= pins.a[ROW_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_burst_fsm.sv
`default_nettype none

module sdram_burst_fsm #(
    parameter int ROW_WIDTH = sdram_geom_pkg::DEF_ROW_WIDTH,
    parameter int COL_WIDTH = sdram_geom_pkg::DEF_COL_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_cmd_pkg::access_t access,
    input  logic [3:0]             burst_len,
    input  logic [1:0]             cas_lat,
    input  logic                   latency_done,
    input  logic                   burst_last,
    output logic                   load_latency,
    output logic                   load_burst,
    output logic                   step,
    output logic                   wr_en,
    output logic                   rd_en,
    output sdram_geom_pkg::bank_t  arr_bank,
    output logic [ROW_WIDTH-1:0]   arr_row,
    output logic [COL_WIDTH-1:0]   arr_col,
    output logic                   dq_oe
);

    sdram_geom_pkg::burst_state_e state;

    // Burst address, col_q points at the next word
    sdram_geom_pkg::bank_t  bank_q;
    logic [ROW_WIDTH-1:0]   row_q;
    logic [COL_WIDTH-1:0]   col_q;

    // Array read issued last cycle, data lands in dq_out next edge
    logic oe_next;

    logic new_access;
    logic read_word;
    logic write_word;

    // A new READ or WRITE preempts whatever is in flight
    assign new_access = access.start_read | access.start_write;
    assign read_word  = !new_access &&
                        ((state == sdram_geom_pkg::st_read_wait && latency_done) ||
                         state == sdram_geom_pkg::st_read_burst);
    assign write_word = !new_access && (state == sdram_geom_pkg::st_write_burst);

    // Timer controls, step during a write load counts word 0
    assign load_latency = access.start_read;
    assign load_burst   = new_access;
    assign step         = access.start_write | read_word | write_word;

    // Word 0 of a write goes straight from the command
    assign wr_en    = access.start_write | write_word;
    assign rd_en    = read_word;
    assign arr_bank = access.start_write ? access.bank : bank_q;
    assign arr_row  = access.start_write ? access.row[ROW_WIDTH-1:0] : row_q;
    assign arr_col  = access.start_write ? access.column[COL_WIDTH-1:0] : col_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= sdram_geom_pkg::st_idle;
            oe_next <= 1'b0;
            dq_oe   <= 1'b0;
        end else if (new_access) begin
            // Drop read words already in the pipe
            oe_next <= 1'b0;
            dq_oe   <= 1'b0;
            if (access.start_write) begin
                state <= (burst_len == 4'd1) ? sdram_geom_pkg::st_idle
                                             : sdram_geom_pkg::st_write_burst;
            end else begin
                // With CL 2 the first array read is due next cycle
                state <= (cas_lat == 2'd2) ? sdram_geom_pkg::st_read_burst
                                           : sdram_geom_pkg::st_read_wait;
            end
        end else begin
            oe_next <= read_word;
            dq_oe   <= oe_next;
            if (read_word || write_word) begin
                if (burst_last) begin
                    state <= sdram_geom_pkg::st_idle;
                end else if (state == sdram_geom_pkg::st_read_wait) begin
                    state <= sdram_geom_pkg::st_read_burst;
                end
            end
        end
    end

    // Address pointer, wraps inside the row
    always_ff @(posedge clk) begin
        if (new_access) begin
            bank_q <= access.bank;
            row_q  <= access.row[ROW_WIDTH-1:0];
            col_q  <= access.start_write ? access.column[COL_WIDTH-1:0] + COL_WIDTH'(1)
                                         : access.column[COL_WIDTH-1:0];
        end else if (read_word || write_word) begin
            col_q <= col_q + COL_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_burst_timer.sv
`default_nettype none

module sdram_burst_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_latency,
    input  logic       load_burst,
    input  logic       step,
    input  logic [1:0] cas_lat,
    input  logic [3:0] burst_len,
    output logic       latency_done,
    output logic       burst_last
);

    // Cycles left before the first array read
    logic [1:0] lat_cnt;
    // Words left after the current one
    logic [2:0] burst_cnt;

    // Latency counter, free running down to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            lat_cnt <= 2'd0;
        end else if (load_latency) begin
            lat_cnt <= cas_lat - 2'd1;
        end else if (lat_cnt != 2'd0) begin
            lat_cnt <= lat_cnt - 2'd1;
        end
    end

    // Word counter
    always_ff @(posedge clk) begin
        if (rst) begin
            burst_cnt <= 3'd0;
        end else if (load_burst) begin
            // Step with load means word 0 already went out
            burst_cnt <= 3'(burst_len - 4'd1 - 4'(step));
        end else if (step && burst_cnt != 3'd0) begin
            burst_cnt <= burst_cnt - 3'd1;
        end
    end

    // One cycle left, so the array read for word 0 happens now
    assign latency_done = (lat_cnt == 2'd1);

    // Current word closes the burst
    assign burst_last = (burst_cnt == 3'd0);

endmodule

`default_nettype wire

//--- source/sdram_array.sv
`default_nettype none

module sdram_array #(
    parameter int ROW_WIDTH = sdram_geom_pkg::DEF_ROW_WIDTH,
    parameter int COL_WIDTH = sdram_geom_pkg::DEF_COL_WIDTH
) (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  sdram_geom_pkg::bank_t               arr_bank,
    input  logic [ROW_WIDTH-1:0]                arr_row,
    input  logic [COL_WIDTH-1:0]                arr_col,
    input  logic [sdram_cmd_pkg::DATA_WIDTH-1:0] dq_in,
    input  logic [sdram_cmd_pkg::DQM_WIDTH-1:0]  dqm,
    output logic [sdram_cmd_pkg::DATA_WIDTH-1:0] dq_out
);

    // Flat index of bank, row and column
    localparam int WORD_ADDR_WIDTH = sdram_geom_pkg::BANK_WIDTH + ROW_WIDTH + COL_WIDTH;
    localparam int DEPTH = 2 ** WORD_ADDR_WIDTH;

    logic [sdram_cmd_pkg::DATA_WIDTH-1:0] mem [DEPTH];
    logic [WORD_ADDR_WIDTH-1:0]           word_addr;

    // Read data stage ahead of the pin register
    logic [sdram_cmd_pkg::DATA_WIDTH-1:0] rd_word;

    assign word_addr = {arr_bank, arr_row, arr_col};

    // Byte-masked write, DQM high blocks the lane
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < sdram_cmd_pkg::DQM_WIDTH; b++) begin
                if (!dqm[b]) begin
                    mem[word_addr][b*8 +: 8] <= dq_in[b*8 +: 8];
                end
            end
        end
    end

    // Synchronous read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[word_addr];
        end
    end

    // Output register, dq_oe qualifies it
    always_ff @(posedge clk) begin
        dq_out <= rd_word;
    end

endmodule

`default_nettype wire

//--- source/sdram_model.sv
`default_nettype none

module sdram_model #(
    parameter int ROW_WIDTH = sdram_geom_pkg::DEF_ROW_WIDTH,
    parameter int COL_WIDTH = sdram_geom_pkg::DEF_COL_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cs,
    input  logic                                 ras,
    input  logic                                 cas,
    input  logic                                 we,
    input  logic [sdram_cmd_pkg::ADDR_WIDTH-1:0] a,
    input  sdram_geom_pkg::bank_t                ba,
    input  logic [sdram_cmd_pkg::DQM_WIDTH-1:0]  dqm,
    input  logic [sdram_cmd_pkg::DATA_WIDTH-1:0] dq_in,
    output logic [sdram_cmd_pkg::DATA_WIDTH-1:0] dq_out,
    output logic                                 dq_oe
);

    sdram_cmd_pkg::pins_t   pins;
    sdram_cmd_pkg::access_t access;

    logic [3:0] burst_len;
    logic [1:0] cas_lat;

    // Timer handshake
    logic load_latency;
    logic load_burst;
    logic step;
    logic latency_done;
    logic burst_last;

    // Array port
    logic                  wr_en;
    logic                  rd_en;
    sdram_geom_pkg::bank_t arr_bank;
    logic [ROW_WIDTH-1:0]  arr_row;
    logic [COL_WIDTH-1:0]  arr_col;

    assign pins = '{cs: cs, ras: ras, cas: cas, we: we, a: a, ba: ba, dqm: dqm};

    sdram_cmd_decode #(
        .ROW_WIDTH (ROW_WIDTH),
        .COL_WIDTH (COL_WIDTH)
    ) u_cmd_decode (
        .clk       (clk),
        .rst       (rst),
        .pins      (pins),
        .access    (access),
        .burst_len (burst_len),
        .cas_lat   (cas_lat)
    );

    sdram_burst_fsm #(
        .ROW_WIDTH (ROW_WIDTH),
        .COL_WIDTH (COL_WIDTH)
    ) u_burst_fsm (
        .clk          (clk),
        .rst          (rst),
        .access       (access),
        .burst_len    (burst_len),
        .cas_lat      (cas_lat),
        .latency_done (latency_done),
        .burst_last   (burst_last),
        .load_latency (load_latency),
        .load_burst   (load_burst),
        .step         (step),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .arr_bank     (arr_bank),
        .arr_row      (arr_row),
        .arr_col      (arr_col),
        .dq_oe        (dq_oe)
    );

    sdram_burst_timer u_burst_timer (
        .clk          (clk),
        .rst          (rst),
        .load_latency (load_latency),
        .load_burst   (load_burst),
        .step         (step),
        .cas_lat      (cas_lat),
        .burst_len    (burst_len),
        .latency_done (latency_done),
        .burst_last   (burst_last)
    );

    // Write data and masks come straight off the pins
    sdram_array #(
        .ROW_WIDTH (ROW_WIDTH),
        .COL_WIDTH (COL_WIDTH)
    ) u_array (
        .clk      (clk),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .arr_bank (arr_bank),
        .arr_row  (arr_row),
        .arr_col  (arr_col),
        .dq_in    (dq_in),
        .dqm      (pins.dqm),
        .dq_out   (dq_out)
    );

endmodule

`default_nettype wire

//--- tests/sdram_model_properties.sv
`default_nettype none

// Checks on the output enable and the burst engine state
module sdram_model_properties (
    input logic       clk,
    input logic       rst,
    input logic       dq_oe,
    input logic [1:0] state
);

    // Any edge with reset leaves the bus undriven
    assert property (@(posedge clk) rst |=> !dq_oe)
        else $error("dq_oe high after an edge with reset asserted");

    // Still low one cycle past the release
    assert property (@(posedge clk) $fell(rst) |=> !dq_oe)
        else $error("dq_oe high in the cycle after reset release");

    // A write burst never drives the bus
    assert property (@(posedge clk) disable iff (rst)
        (state == sdram_geom_pkg::st_write_burst) |-> !dq_oe)
        else $error("dq_oe high while the engine is in write_burst");

    // Only the four defined encodings
    assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && (state inside {sdram_geom_pkg::st_idle,
                                             sdram_geom_pkg::st_read_wait,
                                             sdram_geom_pkg::st_read_burst,
                                             sdram_geom_pkg::st_write_burst}))
        else $error("burst state outside the defined encodings");

endmodule

// State taken from inside the engine
bind sdram_model sdram_model_properties u_model_properties (
    .clk   (clk),
    .rst   (rst),
    .dq_oe (dq_oe),
    .state (u_burst_fsm.state)
);

`default_nettype wire

//--- tests/tb_sdram_model.sv
`default_nettype none

module tb_sdram_model;

    localparam int ROW_W = sdram_geom_pkg::DEF_ROW_WIDTH;
    localparam int COL_W = sdram_geom_pkg::DEF_COL_WIDTH;
    localparam int IDX_W = sdram_geom_pkg::BANK_WIDTH + ROW_W + COL_W;

    // Pin codes as {cs, ras, cas, we}
    localparam logic [3:0] CMD_NOP   = 4'b0111;
    localparam logic [3:0] CMD_ACT   = 4'b0011;
    localparam logic [3:0] CMD_READ  = 4'b0101;
    localparam logic [3:0] CMD_WRITE = 4'b0100;
    localparam logic [3:0] CMD_PRE   = 4'b0010;
    localparam logic [3:0] CMD_MODE  = 4'b0000;

    // Cycle budget of the six tests plus slack
    localparam int BUDGET      = 120 + 400 + 150 + 250 + 80 + 100;
    localparam int MARGIN      = 200;
    localparam int DRAIN_LIMIT = 40;

    typedef struct packed {
        int          due;
        logic [15:0] data;
    } exp_word_t;

    logic                  clk;
    logic                  rst;
    logic                  cs;
    logic                  ras;
    logic                  cas;
    logic                  we;
    logic [12:0]           a;
    sdram_geom_pkg::bank_t ba;
    logic [1:0]            dqm;
    logic [15:0]           dq_in;
    logic [15:0]           dq_out;
    logic                  dq_oe;

    // Reference memory, open-row table and mode
    logic [15:0]      ref_mem [2 ** IDX_W];
    logic             ref_open [4];
    logic [ROW_W-1:0] ref_row [4];
    int               ref_bl;
    int               ref_cl;

    // Write burst in flight
    int               wr_left;
    logic [1:0]       wr_bank;
    logic [ROW_W-1:0] wr_row;
    logic [COL_W-1:0] wr_col;

    // Read scoreboard, words with the edge they appear after
    exp_word_t   sb [$];
    int          cyc = 0;
    int          pending;
    logic        exp_oe;
    logic [15:0] exp_data;

    int          oe_errors = 0;
    int          data_errors = 0;
    int          drain_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int unsigned lcg_state = 6707;

    sdram_model #(
        .ROW_WIDTH (ROW_W),
        .COL_WIDTH (COL_W)
    ) u_sdram_model (
        .clk    (clk),
        .rst    (rst),
        .cs     (cs),
        .ras    (ras),
        .cas    (cas),
        .we     (we),
        .a      (a),
        .ba     (ba),
        .dqm    (dqm),
        .dq_in  (dq_in),
        .dq_out (dq_out),
        .dq_oe  (dq_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        #((BUDGET + MARGIN) * 20);
        $display("Timeout: run did not finish within %0d cycles", BUDGET + MARGIN);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [1:0] b,
                                                    input logic [ROW_W-1:0] r,
                                                    input logic [COL_W-1:0] c);
        return {b, r, c};
    endfunction

    // DQM high keeps the old byte
    function automatic void store_word(input logic [1:0] b, input logic [ROW_W-1:0] r,
                                       input logic [COL_W-1:0] c, input logic [15:0] d,
                                       input logic [1:0] m);
        for (int i = 0; i < 2; i++) begin
            if (!m[i]) begin
                ref_mem[word_index(b, r, c)][i*8 +: 8] = d[i*8 +: 8];
            end
        end
    endfunction

    function automatic int total_errors();
        return oe_errors + data_errors + drain_errors;
    endfunction

    // Reference model, sees the pins on the same edge as the DUT
    always @(posedge clk) begin
        logic      accept;
        exp_word_t w;
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                ref_open[i] = 1'b0;
            end
            ref_bl  = 1;
            ref_cl  = 2;
            wr_left = 0;
            sb.delete();
            exp_oe  <= 1'b0;
            pending <= 0;
        end else begin
            // READ or WRITE to an open bank
            accept = !cs && ras && !cas && ref_open[ba];
            if (accept) begin
                // New access drops every word still to come
                wr_left = 0;
                sb.delete();
                if (!we) begin
                    store_word(ba, ref_row[ba], a[COL_W-1:0], dq_in, dqm);
                    wr_left = ref_bl - 1;
                    wr_bank = ba;
                    wr_row  = ref_row[ba];
                    wr_col  = a[COL_W-1:0] + COL_W'(1);
                end else begin
                    for (int i = 0; i < ref_bl; i++) begin
                        w.due  = cyc + ref_cl + i;
                        w.data = ref_mem[word_index(ba, ref_row[ba],
                                                    a[COL_W-1:0] + COL_W'(i))];
                        sb.push_back(w);
                    end
                end
            end else if (wr_left > 0) begin
                store_word(wr_bank, wr_row, wr_col, dq_in, dqm);
                wr_col  = wr_col + COL_W'(1);
                wr_left = wr_left - 1;
            end
            if (!cs) begin
                case ({ras, cas, we})
                    3'b011: begin
                        ref_open[ba] = 1'b1;
                        ref_row[ba]  = a[ROW_W-1:0];
                    end
                    3'b010: begin
                        for (int i = 0; i < 4; i++) begin
                            if (a[10] || ba == 2'(i)) begin
                                ref_open[i] = 1'b0;
                            end
                        end
                    end
                    3'b000: begin
                        ref_bl = (a[2:0] < 3'd4) ? (1 << a[2:0]) : 1;
                        ref_cl = (a[6:4] == 3'd3) ? 3 : 2;
                    end
                    default: ;
                endcase
            end
            // Word due on the pins after this edge
            if (sb.size() != 0 && sb[0].due == cyc) begin
                exp_oe   <= 1'b1;
                exp_data <= sb[0].data;
                void'(sb.pop_front());
            end else begin
                exp_oe <= 1'b0;
            end
            pending <= sb.size();
        end
        cyc = cyc + 1;
    end

    // Output enable follows the expected read window
    assert property (@(posedge clk) disable iff (rst) dq_oe == exp_oe)
        else begin
            oe_errors++;
            $display("** Error at %0t: dq_oe is %b, expected %b",
                     $time, $sampled(dq_oe), $sampled(exp_oe));
        end

    // Read data in order inside the window
    assert property (@(posedge clk) disable iff (rst) exp_oe |-> dq_out == exp_data)
        else begin
            data_errors++;
            $display("** Error at %0t: dq_out is %h, expected %h",
                     $time, $sampled(dq_out), $sampled(exp_data));
        end

    task automatic send_cmd(input logic [3:0] c, input logic [1:0] b, input logic [12:0] addr,
                            input logic [1:0] m, input logic [15:0] d);
        @(posedge clk);
        {cs, ras, cas, we} <= c;
        ba    <= b;
        a     <= addr;
        dqm   <= m;
        dq_in <= d;
    endtask

    task automatic set_mode(input logic [2:0] code, input logic [2:0] cl);
        send_cmd(CMD_MODE, 2'd0, {6'b0, cl, 1'b0, code}, 2'b00, 16'h0);
    endtask

    task automatic open_row(input logic [1:0] b, input logic [ROW_W-1:0] r);
        send_cmd(CMD_ACT, b, 13'(r), 2'b00, 16'h0);
    endtask

    // Random data, one word per cycle starting with the command
    task automatic write_burst(input logic [1:0] b, input logic [COL_W-1:0] col,
                               input int len, input logic [1:0] mask);
        send_cmd(CMD_WRITE, b, 13'(col), mask, next_rand());
        for (int i = 1; i < len; i++) begin
            send_cmd(CMD_NOP, b, 13'h0, mask, next_rand());
        end
    endtask

    // NOPs until nothing is left to read, with a floor and a cap
    task automatic wait_quiet(input int min_cycles);
        int n;
        n = 0;
        while (n < min_cycles || pending != 0 || exp_oe) begin
            if (n == DRAIN_LIMIT) begin
                drain_errors++;
                $display("Read data still pending %0d cycles after the last command", n);
                break;
            end
            send_cmd(CMD_NOP, 2'd0, 13'h0, 2'b00, 16'h0);
            n++;
        end
    endtask

    task automatic read_back(input logic [1:0] b, input logic [COL_W-1:0] col);
        send_cmd(CMD_READ, b, 13'(col), 2'b00, 16'h0);
        wait_quiet(6);
    endtask

    task automatic apply_reset();
        send_cmd(CMD_NOP, 2'd0, 13'h0, 2'b00, 16'h0);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (total_errors() == errs_at_start) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, total_errors() - errs_at_start);
        end
    endtask

    initial begin
        int               errs;
        int               len;
        logic [COL_W-1:0] col;
        rst   <= 1'b1;
        cs    <= 1'b0;
        ras   <= 1'b1;
        cas   <= 1'b1;
        we    <= 1'b1;
        a     <= 13'h0;
        ba    <= 2'd0;
        dqm   <= 2'b00;
        dq_in <= 16'h0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Burst length 1, both CAS latencies
        errs = total_errors();
        for (int cl = 2; cl <= 3; cl++) begin
            set_mode(3'd0, 3'(cl));
            open_row(2'd0, ROW_W'(3));
            for (int n = 0; n < 2; n++) begin
                col = COL_W'(next_rand());
                write_burst(2'd0, col, 1, 2'b00);
                read_back(2'd0, col);
            end
        end
        finish_test("test 1 mode register and single reads", errs);

        // Bursts of 2, 4 and 8, last one wraps at the row end
        errs = total_errors();
        for (int code = 1; code <= 3; code++) begin
            len = 1 << code;
            set_mode(3'(code), (code == 2) ? 3'd3 : 3'd2);
            open_row(2'd1, ROW_W'(code + 4));
            for (int n = 0; n < 3; n++) begin
                col = (n == 2) ? COL_W'((1 << COL_W) - 3) : COL_W'(next_rand());
                write_burst(2'd1, col, len, 2'b00);
                read_back(2'd1, col);
            end
        end
        finish_test("test 2 full bursts", errs);

        // Full word first, then a masked overwrite
        errs = total_errors();
        set_mode(3'd0, 3'd2);
        open_row(2'd2, ROW_W'(7));
        for (int m = 1; m <= 3; m++) begin
            col = COL_W'(m);
            write_burst(2'd2, col, 1, 2'b00);
            write_burst(2'd2, col, 1, 2'(m));
            read_back(2'd2, col);
        end
        finish_test("test 3 byte masks", errs);

        // Two banks, then accesses to closed banks
        errs = total_errors();
        open_row(2'd2, ROW_W'(5));
        open_row(2'd3, ROW_W'(9));
        write_burst(2'd2, COL_W'(4), 1, 2'b00);
        write_burst(2'd3, COL_W'(4), 1, 2'b00);
        read_back(2'd2, COL_W'(4));
        read_back(2'd3, COL_W'(4));
        send_cmd(CMD_PRE, 2'd2, 13'h000, 2'b00, 16'h0);
        read_back(2'd2, COL_W'(4));
        // Ignored, the reopened row keeps its word
        write_burst(2'd2, COL_W'(4), 1, 2'b00);
        open_row(2'd2, ROW_W'(5));
        read_back(2'd2, COL_W'(4));
        // A10 closes all banks
        send_cmd(CMD_PRE, 2'd0, 13'h400, 2'b00, 16'h0);
        read_back(2'd3, COL_W'(4));
        finish_test("test 4 bank and row handling", errs);

        // Second READ lands mid-burst
        errs = total_errors();
        set_mode(3'd3, 3'd3);
        open_row(2'd1, ROW_W'(2));
        write_burst(2'd1, COL_W'(0), 8, 2'b00);
        write_burst(2'd1, COL_W'(8), 8, 2'b00);
        send_cmd(CMD_READ, 2'd1, 13'h0, 2'b00, 16'h0);
        repeat (4) send_cmd(CMD_NOP, 2'd0, 13'h0, 2'b00, 16'h0);
        read_back(2'd1, COL_W'(8));
        finish_test("test 5 burst truncation", errs);

        // Reset arrives while read data is on the bus
        errs = total_errors();
        send_cmd(CMD_READ, 2'd1, 13'h0, 2'b00, 16'h0);
        repeat (4) send_cmd(CMD_NOP, 2'd0, 13'h0, 2'b00, 16'h0);
        apply_reset();
        // Banks closed and mode back to BL 1 and CL 2
        read_back(2'd1, COL_W'(0));
        open_row(2'd1, ROW_W'(2));
        write_burst(2'd1, COL_W'(0), 1, 2'b00);
        read_back(2'd1, COL_W'(0));
        finish_test("test 6 reset", errs);

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdram_model.f
source/sdram_cmd_pkg.sv
source/sdram_geom_pkg.sv
source/sdram_cmd_decode.sv
source/sdram_burst_fsm.sv
source/sdram_burst_timer.sv
source/sdram_array.sv
source/sdram_model.sv
tests/sdram_model_properties.sv
tests/tb_sdram_model.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the SDRAM model testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sdram_model \
    -f sdram_model.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sdram_model > sim.log 2>&1

grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "Simulation passed, see sim.log" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
